/* Makefile */
SIM := obj_dir/Vtb_modbus_link

.PHONY: all run clean

all: $(SIM)

$(SIM): list.f $(wildcard rtl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -f list.f --top-module tb_modbus_link

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* bench/modbus_link_props.sv */
`default_nettype none

module modbus_link_props (
    input logic            clk,
    input logic            rst_n,
    input logic            rx_valid,
    input frame_pkg::len_t rx_len,
    input logic            tx,
    input logic            tx_en,
    input logic            byte_start,
    input logic            byte_busy
);

    import frame_pkg::*;

    rx_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> (rx_len >= len_t'(1) && rx_len <= len_t'(MAX_BYTES)))
        else $error("rx_valid came with a byte count outside 1 to 8");

    // The RS-485 driver is off only while the line idles high
    tx_idle_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_en |-> tx)
        else $error("tx was low while tx_en was low");

    start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
        byte_start |-> !byte_busy)
        else $error("byte_start came while the transmitter was busy");

endmodule

bind modbus_link modbus_link_props props (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_valid   (rx_valid),
    .rx_len     (rx_len),
    .tx         (tx),
    .tx_en      (tx_en),
    .byte_start (byte_start),
    .byte_busy  (byte_busy)
);

`default_nettype wire

/* bench/tb_modbus_link.sv */
`default_nettype none

module tb_modbus_link;

    import uart_pkg::*;
    import frame_pkg::*;

    localparam int BIT = CLKS_PER_BIT;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   rx = 1'b1;
    len_t                   tx_len = '0;
    logic [MAX_BYTES*8-1:0] tx_data = '0;
    logic                   tx_valid = 1'b0;
    logic                   tx;
    logic                   tx_en;
    len_t                   rx_len;
    logic [MAX_BYTES*8-1:0] rx_data;
    logic                   rx_valid;

    logic [31:0] lfsr = 32'h2f20_9312;
    logic [7:0]  pkt[12];
    frame_t      exp_q[$];
    frame_t      got_q[$];

    modbus_link dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rx_valid) got_q.push_back('{len: rx_len, data: rx_data});
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_frame(input string name, input frame_t exp, input frame_t act);
        if (exp !== act)
            fail_now($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
            fail_now($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    task automatic send_byte(input logic [7:0] b, input logic bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (int'(rand_bits(2)) * BIT + (bad_stop ? BIT : 0)) @(posedge clk); // Short gap
    endtask

    // The model keeps the first eight bytes and drops a packet with a framing error
    task automatic send_packet(input int n, input int bad_idx);
        frame_t f;
        f = '0;
        for (int i = 0; i < n; i++) begin
            pkt[i] = 8'(rand_bits(8));
            if (i < MAX_BYTES) f.data[8*i +: 8] = pkt[i];
        end
        f.len = len_t'(n > MAX_BYTES ? MAX_BYTES : n);
        if (bad_idx < 0) exp_q.push_back(f);
        for (int i = 0; i < n; i++) send_byte(pkt[i], i == bad_idx);
    endtask

    task automatic expect_rx(input string name);
        frame_t got;
        frame_t exp;
        int     t;
        t = 0;
        while (got_q.size() == 0) begin
            @(posedge clk);
            if (++t > 20 * BIT) fail_now($sformatf("%s: no frame arrived on rx_valid", name));
        end
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        got.data &= ~({MAX_BYTES*8{1'b1}} << (8 * exp.len)); // Bytes past len are don't care
        check_frame(name, exp, got);
    endtask

    task automatic expect_no_rx(input string name);
        repeat ((EOP_BITS + 6) * BIT) @(posedge clk);
        if (got_q.size() != 0) fail_now($sformatf("%s: a bad frame was delivered", name));
    endtask

    task automatic start_tx(input len_t len, input logic [MAX_BYTES*8-1:0] data);
        @(posedge clk);
        tx_len   <= len;
        tx_data  <= data;
        tx_valid <= 1'b1;
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    task automatic monitor_tx(input string name, input int n, input logic [63:0] data);
        logic [7:0] b;
        int         t;
        for (int k = 0; k < n; k++) begin
            t = 0;
            do begin
                @(posedge clk);
                if (++t > 4 * BIT) fail_now($sformatf("%s: no start bit on tx", name));
                if (tx_en !== 1'b1) fail_now($sformatf("%s: tx_en low between bytes", name));
            end while (tx !== 1'b0);
            repeat (BIT / 2) @(posedge clk);
            if (tx !== 1'b0) fail_now($sformatf("%s: start bit did not hold", name));
            for (int i = 0; i < 8; i++) begin
                repeat (BIT) @(posedge clk);
                b[i] = tx;
                if (tx_en !== 1'b1) fail_now($sformatf("%s: tx_en dropped mid byte", name));
            end
            repeat (BIT) @(posedge clk);
            if (tx !== 1'b1) fail_now($sformatf("%s: stop bit was low", name));
            if (tx_en !== 1'b1) fail_now($sformatf("%s: tx_en low in stop bit", name));
            check_byte(name, data[8*k +: 8], b);
        end
        t = 0;
        while (tx_en !== 1'b0) begin
            @(posedge clk);
            if (++t > 2 * BIT) fail_now($sformatf("%s: tx_en stayed high", name));
        end
        if (n > 0 && t < BIT / 2)
            fail_now($sformatf("%s: tx_en fell before the stop bit ended", name));
        repeat (12 * BIT) begin
            @(posedge clk);
            if (tx !== 1'b1 || tx_en !== 1'b0)
                fail_now($sformatf("%s: extra activity on tx after the frame", name));
        end
    endtask

    initial begin
        int               n;
        len_t             len;
        logic [63:0]      data;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        for (int r = 0; r < 12; r++) begin
            send_packet(int'(rand_bits(3)) + 1, -1);
            expect_rx("rx_random");
        end

        send_packet(9 + int'(rand_bits(2)), -1);
        expect_rx("rx_overflow");

        n = int'(rand_bits(3)) + 1;
        send_packet(n, int'(rand_bits(3)) % n);
        expect_no_rx("rx_bad_stop");
        send_packet(int'(rand_bits(3)) + 1, -1);
        expect_rx("rx_after_bad");

        for (int r = 0; r < 8; r++) begin
            len  = len_t'(rand_bits(3) + 1);
            data = {rand_bits(32), rand_bits(32)};
            start_tx(len, data);
            monitor_tx("tx_random", int'(len), data);
        end

        // A second request while sending must be ignored
        len  = len_t'(rand_bits(3) + 1);
        data = {rand_bits(32), rand_bits(32)};
        start_tx(len, data);
        fork
            monitor_tx("tx_busy_req", int'(len), data);
            begin
                repeat (3 * BIT) @(posedge clk);
                start_tx(4'd8, ~data);
            end
        join
        start_tx(4'd0, data);
        monitor_tx("tx_len_zero", 0, data);

        len  = len_t'(rand_bits(3) + 1);
        data = {rand_bits(32), rand_bits(32)};
        n    = int'(rand_bits(3)) + 1;
        fork
            send_packet(n, -1);
            begin
                start_tx(len, data);
                monitor_tx("tx_concurrent", int'(len), data);
            end
        join
        expect_rx("rx_concurrent");

        if (exp_q.size() == 0 && got_q.size() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("Frames left over in the model or monitor queues");
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (200000) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* list.f */
rtl/uart_pkg.sv
rtl/frame_pkg.sv
rtl/byte_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/frame_rx.sv
rtl/frame_tx.sv
rtl/modbus_link.sv
bench/modbus_link_props.sv
bench/tb_modbus_link.sv

/* rtl/byte_if.sv */
`default_nettype none

interface byte_if;

    logic [7:0] data;
    logic       valid; // Good byte
    logic       err;   // Byte whose stop bit was low
    logic       eop;   // Line went idle after a packet

    modport src (output data, output valid, output err, output eop);

    modport dst (input data, input valid, input err, input eop);

endinterface

`default_nettype wire

/* rtl/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    localparam int unsigned MAX_BYTES = 8;

    // Byte count of a frame, 0 to MAX_BYTES
    typedef logic [3:0] len_t;

    // Byte 0 sits in data[7:0]
    typedef struct packed {
        len_t                       len;
        logic [MAX_BYTES*8-1:0]     data;
    } frame_t;

endpackage

`default_nettype wire

/* rtl/frame_rx.sv */
`default_nettype none

module frame_rx (
    input  logic              clk,
    input  logic              rst_n,
    byte_if.dst               bus,
    output frame_pkg::frame_t rx_frame,
    output logic              rx_valid
);

    import frame_pkg::*;

    logic [MAX_BYTES*8-1:0] data_q;
    len_t                   cnt;
    logic                   err_seen;
    logic                   store;

    // Bytes past the eighth are dropped
    assign store = bus.valid && (cnt < len_t'(MAX_BYTES));

    always_ff @(posedge clk) begin
        if (store) data_q[8*cnt +: 8] <= bus.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            err_seen <= 1'b0;
            rx_valid <= 1'b0;
            rx_frame <= '0;
        end else begin
            rx_valid <= 1'b0;
            if (bus.eop) begin
                // A framing error anywhere in the packet discards it
                if (!err_seen) begin
                    rx_frame.len  <= cnt;
                    rx_frame.data <= data_q;
                    rx_valid      <= 1'b1;
                end
                cnt      <= '0;
                err_seen <= 1'b0;
            end else begin
                if (store) cnt <= cnt + 1'b1;
                if (bus.err) err_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_tx.sv */
`default_nettype none

module frame_tx (
    input  logic              clk,
    input  logic              rst_n,
    input  frame_pkg::frame_t tx_frame,
    input  logic              tx_valid,
    input  logic              byte_busy,
    output logic              byte_start,
    output logic [7:0]        byte_data,
    output logic              tx_en
);

    import frame_pkg::*;

    logic [MAX_BYTES*8-1:0] data_q;
    len_t                   len_q;
    len_t                   idx;
    logic                   outstanding; // Start issued, busy not yet seen
    logic                   accept;
    logic                   issue;

    assign accept = tx_valid && !tx_en && (tx_frame.len != '0)
                    && (tx_frame.len <= len_t'(MAX_BYTES));
    assign issue  = tx_en && !outstanding && !byte_busy && (idx < len_q);

    always_ff @(posedge clk) begin
        if (accept) data_q <= tx_frame.data;
        if (issue) byte_data <= data_q[8*idx +: 8];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_en       <= 1'b0;
            len_q       <= '0;
            idx         <= '0;
            outstanding <= 1'b0;
            byte_start  <= 1'b0;
        end else begin
            byte_start <= 1'b0;
            if (accept) begin
                tx_en       <= 1'b1;
                len_q       <= tx_frame.len;
                idx         <= '0;
                outstanding <= 1'b0;
            end else if (tx_en) begin
                if (outstanding) begin
                    if (byte_busy) outstanding <= 1'b0;
                end else if (!byte_busy) begin
                    if (issue) begin
                        byte_start  <= 1'b1;
                        idx         <= idx + 1'b1;
                        outstanding <= 1'b1;
                    end else begin
                        tx_en <= 1'b0; // Last stop bit has gone out
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/modbus_link.sv */
`default_nettype none

module modbus_link (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              rx,
    input  frame_pkg::len_t                   tx_len,
    input  logic [frame_pkg::MAX_BYTES*8-1:0] tx_data,
    input  logic                              tx_valid,
    output logic                              tx,
    output logic                              tx_en,
    output frame_pkg::len_t                   rx_len,
    output logic [frame_pkg::MAX_BYTES*8-1:0] rx_data,
    output logic                              rx_valid
);

    import frame_pkg::*;

    frame_t     tx_frame;
    frame_t     rx_frame;
    logic       byte_start;
    logic       byte_busy;
    logic [7:0] byte_data;

    byte_if rx_bus ();

    assign tx_frame.len  = tx_len;
    assign tx_frame.data = tx_data;
    assign rx_len        = rx_frame.len;
    assign rx_data       = rx_frame.data;

    uart_rx u_uart_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .bus   (rx_bus.src)
    );

    frame_rx u_frame_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (rx_bus.dst),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

    frame_tx u_frame_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_frame   (tx_frame),
        .tx_valid   (tx_valid),
        .byte_busy  (byte_busy),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .tx_en      (tx_en)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .tx         (tx),
        .byte_busy  (byte_busy)
    );

endmodule

`default_nettype wire

/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    localparam int unsigned CLK_FREQ = 12_000_000;
    localparam int unsigned BAUD = 750_000;
    localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD; // 16 clocks per bit
    localparam int unsigned EOP_BITS = 12;

    // Counter sizes derived from the line timing
    localparam int unsigned CLK_CNT_W = $clog2(CLKS_PER_BIT);
    localparam int unsigned EOP_CYCLES = EOP_BITS * CLKS_PER_BIT;
    localparam int unsigned EOP_CNT_W = $clog2(EOP_CYCLES);

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
`default_nettype none

module uart_rx (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    byte_if.src  bus
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t               state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic                 fall;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_cnt;
    logic [7:0]           shift;
    logic                 half_end;
    logic                 bit_end;
    logic                 idle_run;
    logic [EOP_CNT_W-1:0] idle_cnt;

    assign fall     = rx_prev & ~rx_sync;
    assign half_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Data bits shift in LSB first
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) shift <= {rx_sync, shift[7:1]};
        if (state == STOP && bit_end) bus.data <= shift;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            idle_run  <= 1'b0;
            idle_cnt  <= '0;
            bus.valid <= 1'b0;
            bus.err   <= 1'b0;
            bus.eop   <= 1'b0;
        end else begin
            bus.valid <= 1'b0;
            bus.err   <= 1'b0;
            bus.eop   <= 1'b0;

            if (idle_run) begin
                if (idle_cnt == EOP_CNT_W'(EOP_CYCLES - 1)) begin
                    bus.eop  <= 1'b1;
                    idle_run <= 1'b0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end

            case (state)
                IDLE: begin
                    if (fall) begin
                        state   <= START;
                        clk_cnt <= '0;
                    end
                end
                START: begin
                    if (half_end) begin
                        clk_cnt <= '0;
                        if (!rx_sync) begin
                            state    <= DATA;
                            bit_cnt  <= '0;
                            idle_run <= 1'b0; // A real start bit keeps the packet open
                        end else begin
                            state <= IDLE; // Glitch on the line
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        clk_cnt   <= '0;
                        state     <= IDLE;
                        bus.valid <= rx_sync;
                        bus.err   <= ~rx_sync;
                        idle_run  <= 1'b1;
                        idle_cnt  <= EOP_CNT_W'(1); // Counts cycles since this sample
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       byte_start,
    input  logic [7:0] byte_data,
    output logic       tx,
    output logic       byte_busy
);

    import uart_pkg::*;

    logic [9:0]           shift;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;
    logic                 bit_end;

    assign bit_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    // The line is the low end of the shift register
    assign tx = shift[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift     <= '1;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            byte_busy <= 1'b0;
        end else if (!byte_busy) begin
            if (byte_start) begin
                shift     <= {1'b1, byte_data, 1'b0}; // Stop, data, start
                clk_cnt   <= '0;
                bit_cnt   <= '0;
                byte_busy <= 1'b1;
            end
        end else if (bit_end) begin
            shift   <= {1'b1, shift[9:1]};
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                byte_busy <= 1'b0; // End of the stop bit
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire
